/* include/prng_tables.svh */
`ifndef PRNG_TABLES_SVH
`define PRNG_TABLES_SVH

// Permutation ahead of the S-box layer. Bit i of the result takes LFSR bit StatePerm[i].
localparam int unsigned StatePerm [64] = '{
   7, 20, 33, 46, 59,  8, 21, 34, 47, 60,  9, 22, 35, 48, 61, 10,
  23, 36, 49, 62, 11, 24, 37, 50, 63, 12, 25, 38, 51,  0, 13, 26,
  39, 52,  1, 14, 27, 40, 53,  2, 15, 28, 41, 54,  3, 16, 29, 42,
  55,  4, 17, 30, 43, 56,  5, 18, 31, 44, 57,  6, 19, 32, 45, 58
};

// Permutation after the S-box layer. Its result is share 0 of the PRNG word.
localparam int unsigned OutPerm [64] = '{
  11, 40,  5, 34, 63, 28, 57, 22, 51, 16, 45, 10, 39,  4, 33, 62,
  27, 56, 21, 50, 15, 44,  9, 38,  3, 32, 61, 26, 55, 20, 49, 14,
  43,  8, 37,  2, 31, 60, 25, 54, 19, 48, 13, 42,  7, 36,  1, 30,
  59, 24, 53, 18, 47, 12, 41,  6, 35,  0, 29, 58, 23, 52, 17, 46
};

// Permutation of share 0 that yields share 1.
localparam int unsigned SharePerm [64] = '{
  19, 56, 29,  2, 39, 12, 49, 22, 59, 32,  5, 42, 15, 52, 25, 62,
  35,  8, 45, 18, 55, 28,  1, 38, 11, 48, 21, 58, 31,  4, 41, 14,
  51, 24, 61, 34,  7, 44, 17, 54, 27,  0, 37, 10, 47, 20, 57, 30,
   3, 40, 13, 50, 23, 60, 33,  6, 43, 16, 53, 26, 63, 36,  9, 46
};

// The 4-bit S-box of the PRINCE block cipher, indexed by the input nibble.
localparam logic [3:0] PrinceSbox [16] = '{
  4'hB, 4'hF, 4'h3, 4'h2, 4'hA, 4'hC, 4'h9, 4'h1,
  4'h6, 4'h7, 4'h8, 4'h0, 4'hE, 4'h5, 4'hD, 4'h4
};

`endif

/* logic/prng_cfg_pkg.sv */
`default_nettype none

// Configuration constants of the secure-wipe subsystem.
package prng_cfg_pkg;

  // Size of the LFSR and of each share of a PRNG word.
  localparam int unsigned LfsrWidth = 64;

  // Width of one entropy beat. Two beats make up a full reseed value.
  localparam int unsigned EntropyWidth = 32;

  // State the LFSR takes on reset. It must not be zero, or the LFSR would lock up.
  localparam logic [LfsrWidth-1:0] LfsrSeedDefault = 64'h3C5A_96E1_0F7B_2D84;

  // Feedback mask of the right-shifting Galois LFSR.
  // It matches the maximal-length polynomial x^64 + x^63 + x^61 + x^60 + 1.
  localparam logic [LfsrWidth-1:0] LfsrTaps = 64'hD800_0000_0000_0000;

  // Number of words in the key register bank.
  localparam int unsigned KeyBankWords = 8;

  // Number of words in the state register bank.
  localparam int unsigned StateBankWords = 4;

  // Address bits needed for the larger of the two banks.
  localparam int unsigned BankAddrWidth = 3;

  // Permutation and S-box tables of the output layer.
  `include "prng_tables.svh"

endpackage

`default_nettype wire

/* logic/wipe_if_pkg.sv */
`default_nettype none

// Types that travel between the PRNG, the arbiter and the bank wipers.
package wipe_if_pkg;

  import prng_cfg_pkg::*;

  // One pseudo-random word in two shares, one per share of a masked register.
  typedef struct packed {
    logic [LfsrWidth-1:0] share0;
    logic [LfsrWidth-1:0] share1;
  } prng_word_t;

  // A single write into a register bank.
  typedef struct packed {
    logic [BankAddrWidth-1:0] addr;
    prng_word_t               data;
  } bank_wr_t;

  // The two entropy beats of a reseed.
  // The first beat lands in the upper half of the LFSR, the second in the lower half.
  typedef struct packed {
    logic [EntropyWidth-1:0] hi;
    logic [EntropyWidth-1:0] lo;
  } entropy_seed_t;

  // States of a bank wiper.
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    WIPE = 2'd1,
    DONE = 2'd2
  } wiper_state_e;

  // States of the PRNG reseed machine.
  typedef enum logic [1:0] {
    RESEED_IDLE = 2'd0,
    WAIT_HI     = 2'd1,
    WAIT_LO     = 2'd2
  } reseed_state_e;

endpackage

`default_nettype wire

/* logic/clearing_prng.sv */
`default_nettype none

// Low-bandwidth PRNG for register clearing.
// A Galois LFSR feeds a permutation, a layer of PRINCE S-boxes and a second permutation.
// The result is share 0, and a further permutation of share 0 gives share 1.
module clearing_prng (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  input  logic                                reseed_valid_i,
  output logic                                reseed_ready_o,

  input  logic                                entropy_valid_i,
  output logic                                entropy_ready_o,
  input  logic [prng_cfg_pkg::EntropyWidth-1:0] entropy_i,

  output logic                                word_valid_o,
  input  logic                                word_ready_i,
  output wipe_if_pkg::prng_word_t             word_o
);

  import prng_cfg_pkg::*;
  import wipe_if_pkg::*;

  reseed_state_e           state_q, state_d;
  logic [EntropyWidth-1:0] hi_q;
  entropy_seed_t           seed;
  logic [LfsrWidth-1:0]    lfsr_q, lfsr_d, lfsr_step;
  logic [LfsrWidth-1:0]    state_perm, sbox_out, share0, share1;
  logic                    reseed_xfer, entropy_xfer, word_xfer, seed_load;

  // The command is taken only while no reseed is running.
  assign reseed_ready_o  = (state_q == RESEED_IDLE);
  assign entropy_ready_o = (state_q == WAIT_HI) || (state_q == WAIT_LO);

  // No word is served while a reseed is pending.
  assign word_valid_o = (state_q == RESEED_IDLE);

  assign reseed_xfer  = reseed_valid_i & reseed_ready_o;
  assign entropy_xfer = entropy_valid_i & entropy_ready_o;
  assign word_xfer    = word_valid_o & word_ready_i;

  // The LFSR is loaded on the edge that accepts the second beat.
  assign seed_load = entropy_xfer & (state_q == WAIT_LO);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RESEED_IDLE: begin
        if (reseed_xfer) begin
          state_d = WAIT_HI;
        end
      end
      WAIT_HI: begin
        if (entropy_xfer) begin
          state_d = WAIT_LO;
        end
      end
      WAIT_LO: begin
        if (entropy_xfer) begin
          state_d = RESEED_IDLE;
        end
      end
      default: begin
        state_d = RESEED_IDLE;
      end
    endcase
  end

  // The first beat waits here until the second one arrives.
  always_ff @(posedge clk_i) begin
    if (entropy_xfer && (state_q == WAIT_HI)) begin
      hi_q <= entropy_i;
    end
  end

  assign seed.hi = hi_q;
  assign seed.lo = entropy_i;

  // One Galois step shifts right and folds the outgoing bit back in through the taps.
  assign lfsr_step = (lfsr_q >> 1) ^ (lfsr_q[0] ? LfsrTaps : '0);

  // Reseeding and stepping never coincide, since words are served only in RESEED_IDLE.
  assign lfsr_d = seed_load ? seed : (word_xfer ? lfsr_step : lfsr_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESEED_IDLE;
      lfsr_q  <= LfsrSeedDefault;
    end else begin
      state_q <= state_d;
      lfsr_q  <= lfsr_d;
    end
  end

  // The output layer is purely combinational, so a word is ready in the cycle it is asked for.
  always_comb begin
    for (int i = 0; i < LfsrWidth; i++) begin
      state_perm[i] = lfsr_q[StatePerm[i]];
    end
  end

  // Every nibble goes through its own S-box.
  always_comb begin
    for (int n = 0; n < LfsrWidth / 4; n++) begin
      sbox_out[4*n +: 4] = PrinceSbox[state_perm[4*n +: 4]];
    end
  end

  always_comb begin
    for (int i = 0; i < LfsrWidth; i++) begin
      share0[i] = sbox_out[OutPerm[i]];
    end
  end

  // Share 1 is a reshuffle of share 0, so both shares are cleared with different bits.
  always_comb begin
    for (int i = 0; i < LfsrWidth; i++) begin
      share1[i] = share0[SharePerm[i]];
    end
  end

  assign word_o.share0 = share0;
  assign word_o.share1 = share1;

endmodule

`default_nettype wire

/* logic/prng_arbiter.sv */
`default_nettype none

// Round-robin arbiter that shares the PRNG word port between two requesters.
// Index 0 is the key bank wiper and index 1 the state bank wiper.
module prng_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    word_valid_i,
  output logic                    word_ready_o,
  input  wipe_if_pkg::prng_word_t word_i,

  input  logic [1:0]              req_i,
  output logic [1:0]              gnt_o,
  output wipe_if_pkg::prng_word_t word_o
);

  logic [1:0] gnt;
  logic       last_q;
  logic       xfer;

  // A lone requester wins outright.
  // With two requesters the one that was not served last is picked.
  always_comb begin
    if (&req_i) begin
      gnt = last_q ? 2'b01 : 2'b10;
    end else begin
      gnt = req_i;
    end
  end

  // Any request pulls a word from the PRNG.
  assign word_ready_o = |req_i;

  // The grant only counts as ready while the PRNG has a word to give.
  assign gnt_o = gnt & {2{word_valid_i}};

  assign xfer = word_valid_i & word_ready_o;

  // The pointer remembers which requester took the last word.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= 1'b0;
    end else if (xfer) begin
      last_q <= gnt[1];
    end
  end

  // Both requesters see the same word; only the granted one takes it.
  assign word_o = word_i;

endmodule

`default_nettype wire

/* logic/bank_wiper.sv */
`default_nettype none

// Sequencer that overwrites every word of one register bank with fresh PRNG output.
// A wipe command starts it, it writes addresses 0 to NumWords-1 in order, then it pulses done.
module bank_wiper #(
  parameter int unsigned NumWords = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    wipe_valid_i,
  output logic                    wipe_ready_o,

  output logic                    rnd_valid_o,
  input  logic                    rnd_ready_i,
  input  wipe_if_pkg::prng_word_t rnd_i,

  output logic                    wr_en_o,
  output wipe_if_pkg::bank_wr_t   wr_o,
  output logic                    done_o
);

  import prng_cfg_pkg::*;
  import wipe_if_pkg::*;

  localparam logic [BankAddrWidth-1:0] LastAddr = BankAddrWidth'(NumWords - 1);

  wiper_state_e             state_q;
  logic [BankAddrWidth-1:0] addr_q;
  logic                     wr_en_q;
  bank_wr_t                 wr_q;
  logic                     done_q;
  logic                     rnd_xfer;

  assign wipe_ready_o = (state_q == IDLE);

  // Words are requested for the whole wipe; without a grant the address simply holds.
  assign rnd_valid_o = (state_q == WIPE);
  assign rnd_xfer    = rnd_valid_o & rnd_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      addr_q  <= '0;
      wr_en_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      wr_en_q <= rnd_xfer;
      done_q  <= 1'b0;
      unique case (state_q)
        IDLE: begin
          if (wipe_valid_i) begin
            state_q <= WIPE;
            addr_q  <= '0;
          end
        end
        WIPE: begin
          if (rnd_xfer) begin
            if (addr_q == LastAddr) begin
              state_q <= DONE;
            end else begin
              addr_q <= addr_q + 1'b1;
            end
          end
        end
        DONE: begin
          // The last write is on the port now, so done follows one cycle later.
          done_q  <= 1'b1;
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Each granted word is written with the address it was requested for.
  always_ff @(posedge clk_i) begin
    if (rnd_xfer) begin
      wr_q.addr <= addr_q;
      wr_q.data <= rnd_i;
    end
  end

  assign wr_en_o = wr_en_q;
  assign wr_o    = wr_q;
  assign done_o  = done_q;

endmodule

`default_nettype wire

/* logic/wipe_top.sv */
`default_nettype none

// Secure-wipe subsystem with one clearing PRNG shared by the key and the state bank wipers.
module wipe_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  input  logic                                reseed_valid_i,
  output logic                                reseed_ready_o,
  input  logic                                entropy_valid_i,
  output logic                                entropy_ready_o,
  input  logic [prng_cfg_pkg::EntropyWidth-1:0] entropy_i,

  input  logic                                key_wipe_valid_i,
  output logic                                key_wipe_ready_o,
  output logic                                key_wr_en_o,
  output wipe_if_pkg::bank_wr_t               key_wr_o,
  output logic                                key_done_o,

  input  logic                                state_wipe_valid_i,
  output logic                                state_wipe_ready_o,
  output logic                                state_wr_en_o,
  output wipe_if_pkg::bank_wr_t               state_wr_o,
  output logic                                state_done_o
);

  import prng_cfg_pkg::*;
  import wipe_if_pkg::*;

  logic       word_valid;
  logic       word_ready;
  prng_word_t prng_word;
  prng_word_t rnd_word;

  // Bit 0 belongs to the key wiper, bit 1 to the state wiper.
  logic [1:0] req;
  logic [1:0] gnt;

  clearing_prng u_prng (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .reseed_valid_i  (reseed_valid_i),
    .reseed_ready_o  (reseed_ready_o),
    .entropy_valid_i (entropy_valid_i),
    .entropy_ready_o (entropy_ready_o),
    .entropy_i       (entropy_i),
    .word_valid_o    (word_valid),
    .word_ready_i    (word_ready),
    .word_o          (prng_word)
  );

  prng_arbiter u_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word_valid_i (word_valid),
    .word_ready_o (word_ready),
    .word_i       (prng_word),
    .req_i        (req),
    .gnt_o        (gnt),
    .word_o       (rnd_word)
  );

  bank_wiper #(
    .NumWords (KeyBankWords)
  ) u_key_wiper (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wipe_valid_i (key_wipe_valid_i),
    .wipe_ready_o (key_wipe_ready_o),
    .rnd_valid_o  (req[0]),
    .rnd_ready_i  (gnt[0]),
    .rnd_i        (rnd_word),
    .wr_en_o      (key_wr_en_o),
    .wr_o         (key_wr_o),
    .done_o       (key_done_o)
  );

  bank_wiper #(
    .NumWords (StateBankWords)
  ) u_state_wiper (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wipe_valid_i (state_wipe_valid_i),
    .wipe_ready_o (state_wipe_ready_o),
    .rnd_valid_o  (req[1]),
    .rnd_ready_i  (gnt[1]),
    .rnd_i        (rnd_word),
    .wr_en_o      (state_wr_en_o),
    .wr_o         (state_wr_o),
    .done_o       (state_done_o)
  );

endmodule

`default_nettype wire

/* verif/prng_ref_pkg.sv */
`default_nettype none

// Reference model of the clearing PRNG and the run constants of the testbench.
package prng_ref_pkg;

  import prng_cfg_pkg::*;
  import wipe_if_pkg::*;

  // Fixed seed of the random stimulus.
  localparam int unsigned RandSeed = 19237;

  // Number of wipe commands per bank and number of reseeds in one run.
  localparam int unsigned NumKeyCmds   = 10;
  localparam int unsigned NumStateCmds = 14;
  localparam int unsigned NumReseeds   = 5;

  // Longest idle gap, in cycles, between two beats or commands on one channel.
  localparam int unsigned MaxGap = 6;

  // Every write takes at least one cycle and every command or beat adds a gap.
  // The margin covers arbitration and reseed stalls.
  localparam int unsigned TimeoutMargin = 4;
  localparam int unsigned CycleLimit =
    ((NumKeyCmds * KeyBankWords + NumStateCmds * StateBankWords) +
     (NumKeyCmds + NumStateCmds + 3 * NumReseeds) * (MaxGap + 2)) * TimeoutMargin;

  // A right-shifting Galois step lets the bit that falls out at the bottom select the taps.
  function automatic logic [LfsrWidth-1:0] lfsr_advance(input logic [LfsrWidth-1:0] s);
    logic [LfsrWidth-1:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ LfsrTaps;
    end
    return n;
  endfunction

  // The first entropy beat fills the upper half, the second beat the lower half.
  function automatic logic [LfsrWidth-1:0] seed_from_beats(input logic [EntropyWidth-1:0] hi,
                                                           input logic [EntropyWidth-1:0] lo);
    return {hi, lo};
  endfunction

  // Share 1 is share 0 put through the share permutation.
  function automatic logic [LfsrWidth-1:0] reshuffle_share(input logic [LfsrWidth-1:0] s0);
    logic [LfsrWidth-1:0] r;
    for (int i = 0; i < LfsrWidth; i++) begin
      r[i] = s0[SharePerm[i]];
    end
    return r;
  endfunction

  // Output word for a given LFSR state.
  // Permute, S-box every nibble, permute again, then derive share 1.
  function automatic prng_word_t expected_word(input logic [LfsrWidth-1:0] s);
    logic [LfsrWidth-1:0] perm;
    logic [LfsrWidth-1:0] subst;
    logic [LfsrWidth-1:0] s0;
    prng_word_t           w;
    for (int i = 0; i < LfsrWidth; i++) begin
      perm[i] = s[StatePerm[i]];
    end
    for (int n = 0; n < LfsrWidth / 4; n++) begin
      subst[4*n +: 4] = PrinceSbox[perm[4*n +: 4]];
    end
    for (int i = 0; i < LfsrWidth; i++) begin
      s0[i] = subst[OutPerm[i]];
    end
    w.share0 = s0;
    w.share1 = reshuffle_share(s0);
    return w;
  endfunction

endpackage

`default_nettype wire

/* verif/wipe_tb.sv */
`default_nettype none

module wipe_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import prng_cfg_pkg::*;
  import wipe_if_pkg::*;
  import prng_ref_pkg::*;

  logic clk = 1'b0;
  logic rst_n;
  logic stim_on;

  // Channel 0 carries the key wipe command, 1 the state wipe and 2 the reseed.
  logic [2:0] cmd_valid;
  logic [2:0] cmd_ready;
  int         cmd_sent [3];
  int         cmd_gap [3];

  logic                    entropy_valid, entropy_ready;
  logic [EntropyWidth-1:0] entropy;
  int                      entropy_gap;

  logic     key_wr_en, state_wr_en, key_done, state_done;
  bank_wr_t key_wr, state_wr;

  // Model and scoreboard state, updated at the falling edge.
  logic [LfsrWidth-1:0]    model_lfsr;
  logic [EntropyWidth-1:0] hi_beat;
  logic                    pending, pend_prev;
  int                      beats, reseeds_done, cycle;
  logic                    active [2];
  int exp_addr [2], wr_cnt [2], done_cnt [2], starve [2], last_wr_cycle [2];
  int value_errs, proto_errs, timeouts;
  logic finished;

  wipe_top dut_i (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .reseed_valid_i     (cmd_valid[2]),
    .reseed_ready_o     (cmd_ready[2]),
    .entropy_valid_i    (entropy_valid),
    .entropy_ready_o    (entropy_ready),
    .entropy_i          (entropy),
    .key_wipe_valid_i   (cmd_valid[0]),
    .key_wipe_ready_o   (cmd_ready[0]),
    .key_wr_en_o        (key_wr_en),
    .key_wr_o           (key_wr),
    .key_done_o         (key_done),
    .state_wipe_valid_i (cmd_valid[1]),
    .state_wipe_ready_o (cmd_ready[1]),
    .state_wr_en_o      (state_wr_en),
    .state_wr_o         (state_wr),
    .state_done_o       (state_done)
  );

  always #4 clk = ~clk;

  function automatic int words_in_bank(input int b);
    return (b == 0) ? int'(KeyBankWords) : int'(StateBankWords);
  endfunction

  function automatic string name_of_bank(input int b);
    return (b == 0) ? "key" : "state";
  endfunction

  function automatic int cmd_total(input int c);
    return (c == 0) ? int'(NumKeyCmds) : ((c == 1) ? int'(NumStateCmds) : int'(NumReseeds));
  endfunction

  task automatic log_mismatch(input string msg);
    value_errs++;
    $display("ERR %t: %s", $realtime, msg);
  endtask

  task automatic note_violation(input string msg);
    proto_errs++;
    $display("Protocol problem at cycle %0d: %s", cycle, msg);
  endtask

  // A write consumes one model word; the other bank counts as waiting if it is mid-wipe.
  task automatic score_bank_write(input int b, input logic en, input bank_wr_t wr);
    prng_word_t exp;
    if (en) begin
      exp = expected_word(model_lfsr);
      assert (active[b])
        else note_violation({name_of_bank(b), " bank wrote with no wipe running"});
      assert (!pend_prev)
        else note_violation("a bank write used a word while a reseed was pending");
      assert (wr.data == exp) else log_mismatch($sformatf("%s data %h, expected %h",
                                                         name_of_bank(b), wr.data, exp));
      assert (wr.data.share1 == reshuffle_share(wr.data.share0))
        else log_mismatch($sformatf("%s share1 is not the permuted share0", name_of_bank(b)));
      assert (int'(wr.addr) == exp_addr[b])
        else log_mismatch($sformatf("%s address %0d, expected %0d",
                                    name_of_bank(b), wr.addr, exp_addr[b]));
      model_lfsr = lfsr_advance(model_lfsr);
      exp_addr[b]++;
      wr_cnt[b]++;
      last_wr_cycle[b] = cycle;
      starve[b] = 0;
      if (active[1-b] && exp_addr[1-b] < words_in_bank(1 - b)) begin
        starve[1-b]++;
      end
      assert (starve[1-b] <= 1) else note_violation({name_of_bank(1 - b), " bank was starved"});
    end
  endtask

  task automatic verify_done_pulse(input int b, input logic done);
    if (done) begin
      assert (active[b] && exp_addr[b] == words_in_bank(b))
        else note_violation({name_of_bank(b), " done pulse came before all addresses were written"});
      assert (last_wr_cycle[b] == cycle - 1)
        else note_violation({name_of_bank(b), " done pulse did not follow the last write"});
      active[b] = 1'b0;
      done_cnt[b]++;
    end
  endtask

  // Handshakes seen here complete on the coming rising edge.
  task automatic track_handshakes();
    pend_prev = pending;
    assert (cmd_ready[2] == !pending)
      else note_violation("reseed ready disagrees with the reseed");
    if (cmd_valid[2] && cmd_ready[2]) begin
      pending = 1'b1;
      beats   = 0;
    end else if (entropy_valid && entropy_ready) begin
      assert (pending) else note_violation("an entropy beat was taken with no reseed pending");
      if (beats == 0) begin
        hi_beat = entropy;
        beats   = 1;
      end else begin
        model_lfsr = seed_from_beats(hi_beat, entropy);
        pending    = 1'b0;
        reseeds_done++;
      end
    end
    for (int b = 0; b < 2; b++) begin
      // A wiper is ready exactly while it has no wipe running.
      assert (cmd_ready[b] == !active[b])
        else note_violation({name_of_bank(b), " wipe ready disagrees with the wipe in progress"});
      if (cmd_valid[b] && cmd_ready[b]) begin
        assert (!active[b]) else note_violation({name_of_bank(b), " wipe taken while busy"});
        active[b]   = 1'b1;
        exp_addr[b] = 0;
        starve[b]   = 0;
      end
    end
  endtask

  // Outputs are stable at the falling edge, halfway between two stimulus updates.
  always @(negedge clk) begin
    if (rst_n) begin
      cycle++;
      assert (!(key_wr_en && state_wr_en)) else note_violation("both banks wrote in one cycle");
      score_bank_write(0, key_wr_en, key_wr);
      score_bank_write(1, state_wr_en, state_wr);
      verify_done_pulse(0, key_done);
      verify_done_pulse(1, state_done);
      track_handshakes();
      finished = (done_cnt[0] == int'(NumKeyCmds)) && (done_cnt[1] == int'(NumStateCmds)) &&
                 (reseeds_done == int'(NumReseeds)) && !pending && !active[0] && !active[1];
    end
  end

  // Each channel holds valid until the transfer, then idles for a random gap.
  // Reseeds start only after the first key wipe has finished.
  always @(posedge clk) begin
    if (stim_on) begin
      for (int c = 0; c < 3; c++) begin
        if (cmd_valid[c] && cmd_ready[c]) begin
          cmd_valid[c] <= 1'b0;
          cmd_gap[c]   <= int'($urandom_range(MaxGap, 0));
        end else if (!cmd_valid[c] && cmd_sent[c] < cmd_total(c) &&
                     (c != 2 || done_cnt[0] > 0)) begin
          if (cmd_gap[c] == 0) begin
            cmd_valid[c] <= 1'b1;
            cmd_sent[c]  <= cmd_sent[c] + 1;
          end else begin
            cmd_gap[c] <= cmd_gap[c] - 1;
          end
        end
      end
      if (entropy_valid && entropy_ready) begin
        entropy_valid <= 1'b0;
        entropy_gap   <= int'($urandom_range(MaxGap, 0));
      end else if (!entropy_valid) begin
        if (entropy_gap == 0) begin
          entropy_valid <= 1'b1;
          entropy       <= $urandom();
        end else begin
          entropy_gap <= entropy_gap - 1;
        end
      end
    end
  end

  initial begin
    $timeformat(-9, 1, " ns", 10);
    void'($urandom(RandSeed));
    rst_n <= 1'b0;
    stim_on <= 1'b0;
    cmd_valid <= '0;
    entropy_valid <= 1'b0;
    entropy <= '0;
    entropy_gap <= 0;
    model_lfsr = LfsrSeedDefault;
    hi_beat = '0;
    pending = 1'b0;
    pend_prev = 1'b0;
    beats = 0;
    reseeds_done = 0;
    cycle = 0;
    value_errs = 0;
    proto_errs = 0;
    timeouts = 0;
    finished = 1'b0;
    // Zero initial gaps make both banks start a wipe on the same cycle.
    for (int i = 0; i < 3; i++) begin
      cmd_sent[i] <= 0;
      cmd_gap[i]  <= 0;
    end
    for (int b = 0; b < 2; b++) begin
      active[b] = 1'b0;
      exp_addr[b] = 0;
      wr_cnt[b] = 0;
      done_cnt[b] = 0;
      starve[b] = 0;
      last_wr_cycle[b] = -2;
    end
    repeat (5) @(posedge clk);
    rst_n   <= 1'b1;
    stim_on <= 1'b1;
    while (!finished && cycle < int'(CycleLimit)) begin
      @(posedge clk);
    end
    if (!finished) begin
      timeouts++;
      $display("Timeout: the wipes and reseeds did not finish within %0d cycles", CycleLimit);
    end else begin
      assert (wr_cnt[0] == int'(NumKeyCmds * KeyBankWords))
        else log_mismatch($sformatf("key bank saw %0d writes", wr_cnt[0]));
      assert (wr_cnt[1] == int'(NumStateCmds * StateBankWords))
        else log_mismatch($sformatf("state bank saw %0d writes", wr_cnt[1]));
    end
    $display("Summary: %0d value errors, %0d protocol errors, %0d timeouts",
             value_errs, proto_errs, timeouts);
    if (value_errs + proto_errs + timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
logic/prng_cfg_pkg.sv
logic/wipe_if_pkg.sv
logic/clearing_prng.sv
logic/prng_arbiter.sv
logic/bank_wiper.sv
logic/wipe_top.sv
verif/prng_ref_pkg.sv
verif/wipe_tb.sv

/* run.sh */
#!/bin/sh
# Builds the secure-wipe testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f all.f --top-module wipe_tb -Mdir obj_dir -o wipe_sim \
  && ./obj_dir/wipe_sim > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
